// File: files.f
rv_core_pkg.sv
core_ifs.sv
regfile.sv
decode_stage.sv
execute_stage.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator, fail on the testbench's fail line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_core -f files.f -o tb_sim || exit 1
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
! grep -q "Simulation failed" sim.log && grep -q "Simulation passed" sim.log || exit 1

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_core_pkg::*;

  localparam int NUM_REGS = 32;
  // instruction count of each test in order
  localparam int num_insts = 31 + 11 + 11 + 10 + 37 + 200;
  // up to 3 cycles per instruction plus the drains
  localparam int max_cycles = num_insts * 4 + 100;

  logic            clock;
  logic            rst_n;
  logic            inst_valid;
  logic [xlen-1:0] inst;
  logic            retire_valid;
  logic            retire_we;
  logic            retire_illegal;
  reg_idx_t        retire_rd;
  logic [xlen-1:0] retire_data;
  logic [xlen-1:0] model_regs [32];
  // {we, illegal, rd, data} in retire order
  logic [38:0]     exp_q [$];
  int              errors;
  int              checks;
  integer          seed;

  rv_core #(.NUM_REGS(NUM_REGS)) u_rv_core (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                         logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                         reg_idx_t rd);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, OP_LUI};
  endfunction

  // in-order model needs no forwarding case
  task automatic predict(logic [31:0] i);
    logic [6:0]  opc, f7;
    logic [2:0]  f3;
    logic [31:0] a, b, res, sra;
    logic        alt, bad, we;
    opc = i[6:0];
    f3  = i[14:12];
    f7  = i[31:25];
    alt = f7 == 7'h20;
    a   = model_regs[i[19:15]];
    b   = (opc == OP_REG) ? model_regs[i[24:20]] : {{20{i[31]}}, i[31:20]};
    sra = $signed(a) >>> b[4:0];
    if (opc == OP_REG)
      bad = f7 != 7'h00 && !(alt && (f3 == 3'd0 || f3 == 3'd5));
    else if (opc == OP_IMM)
      bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && !alt);
    else
      bad = opc != OP_LUI;
    case (f3)
      3'd0: res = (opc == OP_REG && alt) ? a - b : a + b;
      3'd1: res = a << b[4:0];
      3'd2: res = {31'b0, $signed(a) < $signed(b)};
      3'd3: res = {31'b0, a < b};
      3'd4: res = a ^ b;
      3'd5: res = alt ? sra : a >> b[4:0];
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    if (opc == OP_LUI)
      res = {i[31:12], 12'h000};
    if (bad)
      res = '0;
    we = !bad && i[11:7] != 5'd0;
    if (we)
      model_regs[i[11:7]] = res;
    exp_q.push_back({we, bad, i[11:7], res});
  endtask

  // one strobe followed by gap idle cycles
  task automatic send(logic [31:0] i, int gap);
    predict(i);
    inst_valid = 1'b1;
    inst       = i;
    @(posedge clock);
    #1;
    inst_valid = 1'b0;
    inst       = '0;
    repeat (gap) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic drain_and_report(string name, int err_before);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 2) begin
      @(posedge clock);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR at %0t: %0d instructions never retired", $time, exp_q.size());
      errors++;
      exp_q.delete();
    end
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  task automatic compare_field(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  always @(negedge clock) begin
    logic [38:0] e;
    if (rst_n && retire_valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t: retire_valid with no instruction outstanding", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        compare_field("retire_we", 32'(e[38]), 32'(retire_we));
        compare_field("retire_illegal", 32'(e[37]), 32'(retire_illegal));
        compare_field("retire_rd", 32'(e[36:32]), 32'(retire_rd));
        compare_field("retire_data", e[31:0], retire_data);
      end
    end
  end

  // ADD xr, xr, x0 back to back for each register
  task automatic read_regs();
    for (int r = 1; r < 32; r++) begin
      send(enc_r(7'h00, 5'd0, reg_idx_t'(r), 3'd0, reg_idx_t'(r)), 0);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    repeat (6) begin
      @(posedge clock);
      #1;
    end
    read_regs();
    drain_and_report("reset", e0);
  endtask

  task automatic test_imm_ops();
    int e0;
    e0 = errors;
    send(enc_u(20'h80000, 5'd1), 2);
    send(enc_u(20'hfffff, 5'd2), 2);
    // negative immediate except for the shifts
    for (int f = 0; f < 8; f++) begin
      send(enc_i((f == 1 || f == 5) ? 12'h015 : 12'hff5, 5'd1, 3'(f), reg_idx_t'(f + 3)), 2);
    end
    send(enc_i(12'h415, 5'd1, 3'd5, 5'd11), 2);
    drain_and_report("immediate ops", e0);
  endtask

  task automatic test_reg_ops();
    int e0;
    e0 = errors;
    // 37 masks to a shift of 5
    send(enc_i(12'd37, 5'd0, 3'd0, 5'd13), 1);
    for (int alt = 0; alt < 2; alt++) begin
      for (int f = 0; f < 8; f++) begin
        if (alt == 0 || f == 0 || f == 5) begin
          send(enc_r(alt ? 7'h20 : 7'h00, 5'd13, 5'd1, 3'(f), reg_idx_t'(14 + f + alt)), 1);
        end
      end
    end
    drain_and_report("register ops", e0);
  endtask

  task automatic test_forwarding();
    int e0;
    e0 = errors;
    send(enc_i(12'd5, 5'd0, 3'd0, 5'd1), 0);
    send(enc_i(12'd3, 5'd1, 3'd0, 5'd2), 0);
    send(enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd3), 0);
    send(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4), 0);
    send(enc_i(12'd100, 5'd0, 3'd0, 5'd5), 0);
    send(enc_i(12'd1, 5'd0, 3'd4, 5'd6), 0);
    // x5 from writeback then x7 from execute with x6 from writeback
    send(enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd7), 0);
    send(enc_r(7'h00, 5'd6, 5'd7, 3'd1, 5'd8), 0);
    send(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd1), 0);
    send(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd1), 0);
    drain_and_report("forwarding", e0);
  endtask

  task automatic test_x0_illegal();
    int e0;
    e0 = errors;
    send(enc_i(12'd123, 5'd0, 3'd0, 5'd0), 0);
    send(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9), 0);
    send(32'hffff_ffff, 0);
    send(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3), 0);
    send(enc_i(12'h405, 5'd1, 3'd1, 5'd4), 0);
    send(enc_r(7'h20, 5'd2, 5'd1, 3'd4, 5'd5), 0);
    read_regs();
    drain_and_report("x0 and illegal", e0);
  endtask

  task automatic test_random_stream();
    int          e0;
    logic [31:0] r, s, i;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    e0 = errors;
    for (int k = 0; k < 200; k++) begin
      r   = $random(seed);
      s   = $random(seed);
      f3  = r[7:5];
      imm = s[11:0];
      f7  = (s[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      if (f3 == 3'd1 || f3 == 3'd5)
        imm[11:5] = (f3 == 3'd5 && s[11]) ? 7'h20 : 7'h00;
      if (r[31:30] == 2'd0)
        i = enc_u(s[19:0], r[4:0]);
      else if (r[31:30] == 2'd1)
        i = enc_i(imm, r[12:8], f3, r[4:0]);
      else
        i = enc_r(f7, r[17:13], r[12:8], f3, r[4:0]);
      send(i, int'(s[29:28]) % 3);
    end
    drain_and_report("random stream", e0);
  endtask

  initial begin
    errors     = 0;
    checks     = 0;
    seed       = 2;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (2) @(posedge clock);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_imm_ops();
    test_reg_ops();
    test_forwarding();
    test_x0_illegal();
    test_random_stream();
    $display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             u_rv_core.u_asserts.fail_count);
    if (errors == 0 && u_rv_core.u_asserts.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(max_cycles * 8);
    $display("ERROR: watchdog expired after %0d cycles", max_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts (
  input wire                        clock,
  input wire                        rst_n,
  input wire                        inst_valid,
  input wire                        retire_valid,
  input wire                        retire_we,
  input wire                        retire_illegal,
  input wire rv_core_pkg::reg_idx_t retire_rd
);
  int fail_count = 0;

  // strobe to retire is always two edges
  latency_chk: assert property (@(posedge clock) disable iff (!rst_n)
    retire_valid == $past(inst_valid, 2))
    else begin
      $error("retire_valid not two cycles after inst_valid");
      fail_count++;
    end

  we_valid_chk: assert property (@(posedge clock) disable iff (!rst_n)
    retire_we |-> retire_valid)
    else begin
      $error("retire_we high without retire_valid");
      fail_count++;
    end

  we_illegal_chk: assert property (@(posedge clock) disable iff (!rst_n)
    retire_illegal |-> !retire_we)
    else begin
      $error("retire_we high on an illegal instruction");
      fail_count++;
    end

  // x0 is never written
  we_x0_chk: assert property (@(posedge clock) disable iff (!rst_n)
    (retire_rd == 5'd0) |-> !retire_we)
    else begin
      $error("retire_we high with retire_rd of zero");
      fail_count++;
    end

endmodule

bind rv_core rv_core_asserts u_asserts (.*);

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int NUM_REGS = 32
) (
  input  wire                            clock,
  input  wire                            rst_n,
  input  wire                            inst_valid,
  input  wire [rv_core_pkg::xlen-1:0]    inst,
  output logic                           retire_valid,
  output logic                           retire_we,
  output logic                           retire_illegal,
  output rv_core_pkg::reg_idx_t          retire_rd,
  output logic [rv_core_pkg::xlen-1:0]   retire_data
);
  import rv_core_pkg::*;

  reg_idx_t        raddr_a;
  reg_idx_t        raddr_b;
  logic [xlen-1:0] rdata_a;
  logic [xlen-1:0] rdata_b;

  issue_if  u_issue ();
  retire_if u_retire ();

  decode_stage #(.NUM_REGS(NUM_REGS)) u_decode (
    .clock      (clock),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b),
    .raddr_a    (raddr_a),
    .raddr_b    (raddr_b),
    .iss        (u_issue.dec),
    .ret        (u_retire.fwd)
  );

  execute_stage u_execute (
    .clock (clock),
    .rst_n (rst_n),
    .iss   (u_issue.exe),
    .ret   (u_retire.drv)
  );

  regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
    .clock   (clock),
    .rst_n   (rst_n),
    .raddr_a (raddr_a),
    .raddr_b (raddr_b),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b),
    .wb      (u_retire.wb)
  );

  assign retire_valid   = u_retire.valid;
  assign retire_we      = u_retire.we;
  assign retire_illegal = u_retire.illegal;
  assign retire_rd      = u_retire.rd;
  assign retire_data    = u_retire.data;

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire    clock,
  input  wire    rst_n,
  issue_if.exe   iss,
  retire_if.drv  ret
);
  import rv_core_pkg::*;

  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_out;

  assign a     = iss.operand_a;
  assign b     = iss.operand_b;
  // only the low bits count for shifts
  assign shamt = b[4:0];

  always_comb begin
    case (iss.alu_op)
      ALU_ADD:    alu_out = a + b;
      ALU_SUB:    alu_out = a - b;
      ALU_SLL:    alu_out = a << shamt;
      ALU_SLT:    alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:   alu_out = {{(xlen-1){1'b0}}, a < b};
      ALU_XOR:    alu_out = a ^ b;
      ALU_SRL:    alu_out = a >> shamt;
      ALU_SRA:    alu_out = $unsigned($signed(a) >>> shamt);
      ALU_OR:     alu_out = a | b;
      ALU_AND:    alu_out = a & b;
      ALU_PASS_B: alu_out = b;
      default:    alu_out = '0;
    endcase
  end

  assign iss.ex_result = alu_out;

  // writeback register, flags qualified by valid
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ret.valid   <= 1'b0;
      ret.we      <= 1'b0;
      ret.illegal <= 1'b0;
      ret.rd      <= '0;
    end else begin
      ret.valid   <= iss.valid;
      ret.we      <= iss.valid && iss.we;
      ret.illegal <= iss.valid && iss.illegal;
      ret.rd      <= iss.rd;
    end
  end

  always_ff @(posedge clock) begin
    ret.data <= iss.illegal ? '0 : alu_out;
  end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
  parameter int NUM_REGS = 32
) (
  input  wire                            clock,
  input  wire                            rst_n,
  input  wire                            inst_valid,
  input  wire [rv_core_pkg::xlen-1:0]    inst,
  input  wire [rv_core_pkg::xlen-1:0]    rdata_a,
  input  wire [rv_core_pkg::xlen-1:0]    rdata_b,
  output rv_core_pkg::reg_idx_t          raddr_a,
  output rv_core_pkg::reg_idx_t          raddr_b,
  issue_if.dec                           iss,
  retire_if.fwd                          ret
);
  import rv_core_pkg::*;

  rtype_t          f;
  opcode_e         op;
  alu_op_e         dec_op;
  logic            known;
  logic            bad_funct;
  logic            use_rs1;
  logic            use_rs2;
  logic            reg_bad;
  logic            illegal;
  logic            dec_we;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] u_imm;
  logic [xlen-1:0] fwd_a;
  logic [xlen-1:0] fwd_b;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  assign f     = rtype_t'(inst);
  assign op    = opcode_e'(f.opcode);
  assign i_imm = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign u_imm = {inst[31:12], 12'b0};

  assign raddr_a = f.rs1;
  assign raddr_b = f.rs2;

  always_comb begin
    dec_op    = ALU_ADD;
    known     = 1'b1;
    bad_funct = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (op)
      OP_LUI: dec_op = ALU_PASS_B;
      OP_IMM: begin
        use_rs1 = 1'b1;
        case (f.funct3)
          3'b000: dec_op = ALU_ADD;
          3'b001: begin
            dec_op    = ALU_SLL;
            bad_funct = f.funct7 != F7_BASE;
          end
          3'b010: dec_op = ALU_SLT;
          3'b011: dec_op = ALU_SLTU;
          3'b100: dec_op = ALU_XOR;
          3'b101: begin
            dec_op    = (f.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            bad_funct = f.funct7 != F7_BASE && f.funct7 != F7_ALT;
          end
          3'b110: dec_op = ALU_OR;
          default: dec_op = ALU_AND;
        endcase
      end
      OP_REG: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        // alternate funct7 only for sub and sra
        bad_funct = !(f.funct7 == F7_BASE ||
                      (f.funct7 == F7_ALT && (f.funct3 == 3'b000 || f.funct3 == 3'b101)));
        case (f.funct3)
          3'b000: dec_op = (f.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          3'b001: dec_op = ALU_SLL;
          3'b010: dec_op = ALU_SLT;
          3'b011: dec_op = ALU_SLTU;
          3'b100: dec_op = ALU_XOR;
          3'b101: dec_op = (f.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          3'b110: dec_op = ALU_OR;
          default: dec_op = ALU_AND;
        endcase
      end
      default: known = 1'b0;
    endcase
  end

  // RV32E rejects x16 and up
  assign reg_bad = (int'(f.rd) >= NUM_REGS) ||
                   (use_rs1 && int'(f.rs1) >= NUM_REGS) ||
                   (use_rs2 && int'(f.rs2) >= NUM_REGS);
  assign illegal = !known || bad_funct || reg_bad;
  assign dec_we  = !illegal && (f.rd != '0);

  // execute beats writeback beats the register file
  function automatic logic [xlen-1:0] pick_src(
    input reg_idx_t        idx,
    input logic [xlen-1:0] rf_val,
    input logic            ex_wr,
    input reg_idx_t        ex_rd,
    input logic [xlen-1:0] ex_val,
    input logic            wb_wr,
    input reg_idx_t        wb_rd,
    input logic [xlen-1:0] wb_val
  );
    if (idx == '0) return '0;
    if (ex_wr && ex_rd == idx) return ex_val;
    if (wb_wr && wb_rd == idx) return wb_val;
    return rf_val;
  endfunction

  assign fwd_a = pick_src(f.rs1, rdata_a, iss.valid && iss.we, iss.rd, iss.ex_result,
                          ret.valid && ret.we, ret.rd, ret.data);
  assign fwd_b = pick_src(f.rs2, rdata_b, iss.valid && iss.we, iss.rd, iss.ex_result,
                          ret.valid && ret.we, ret.rd, ret.data);

  assign op_a = (op == OP_LUI) ? '0 : fwd_a;
  assign op_b = (op == OP_LUI) ? u_imm
              : (op == OP_IMM) ? i_imm
              : fwd_b;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      iss.valid   <= 1'b0;
      iss.we      <= 1'b0;
      iss.illegal <= 1'b0;
      iss.rd      <= '0;
    end else begin
      iss.valid <= inst_valid;
      if (inst_valid) begin
        iss.we      <= dec_we;
        iss.illegal <= illegal;
        iss.rd      <= f.rd;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid) begin
      iss.alu_op    <= dec_op;
      iss.operand_a <= op_a;
      iss.operand_b <= op_b;
    end
  end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile #(
  parameter int NUM_REGS = 32
) (
  input  wire                            clock,
  input  wire                            rst_n,
  input  rv_core_pkg::reg_idx_t          raddr_a,
  input  rv_core_pkg::reg_idx_t          raddr_b,
  output logic [rv_core_pkg::xlen-1:0]   rdata_a,
  output logic [rv_core_pkg::xlen-1:0]   rdata_b,
  retire_if.wb                           wb
);
  import rv_core_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  logic [xlen-1:0] regs [NUM_REGS];
  logic            wr_en;

  // x0 and indices past the file are never written
  assign wr_en = wb.valid && wb.we && (wb.rd != '0) && (int'(wb.rd) < NUM_REGS);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.rd[IDX_W-1:0]] <= wb.data;
    end
  end

  // async read, zero for x0 and out of range
  assign rdata_a = (raddr_a == '0 || int'(raddr_a) >= NUM_REGS) ? '0
                 : regs[raddr_a[IDX_W-1:0]];
  assign rdata_b = (raddr_b == '0 || int'(raddr_b) >= NUM_REGS) ? '0
                 : regs[raddr_b[IDX_W-1:0]];

endmodule

`default_nettype wire

// File: core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decode to execute
interface issue_if;
  import rv_core_pkg::*;

  logic             valid;
  alu_op_e          alu_op;
  logic [xlen-1:0]  operand_a;
  logic [xlen-1:0]  operand_b;
  reg_idx_t         rd;
  logic             we;
  logic             illegal;
  // live ALU output, fed back for forwarding
  logic [xlen-1:0]  ex_result;

  modport dec (output valid, alu_op, operand_a, operand_b, rd, we, illegal,
               input ex_result);
  modport exe (input valid, alu_op, operand_a, operand_b, rd, we, illegal,
               output ex_result);
endinterface

// execute to writeback
interface retire_if;
  import rv_core_pkg::*;

  logic             valid;
  logic             we;
  logic             illegal;
  reg_idx_t         rd;
  logic [xlen-1:0]  data;

  modport drv (output valid, we, illegal, rd, data);
  modport wb  (input valid, we, rd, data);
  modport fwd (input valid, we, rd, data);
  modport mon (input valid, we, illegal, rd, data);
endinterface

`default_nettype wire

// File: rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  localparam int xlen = 32;

  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // funct7 values accepted for register ops and shifts
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  typedef enum logic [6:0] {
    OP_LUI = 7'b0110111,
    OP_IMM = 7'b0010011,
    OP_REG = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // R-type layout, other formats reuse its fields
  typedef struct packed {
    funct7_t  funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    funct3_t  funct3;
    reg_idx_t rd;
    logic [6:0] opcode;
  } rtype_t;

endpackage

`default_nettype wire
